//--- lpif_pkg.sv
// LPIF link-layer flit types and widths shared by the upstream and downstream paths
package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit field widths

  // Link state and protocol id
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;

  // Payload and its check byte
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 8;

  // Whole flit, 145 bits
  // Three single-bit qualifiers: dvalid, crc_valid, valid
  localparam int FLIT_W   = STATE_W + PROTID_W + DATA_W + CRC_W + 3;

  ////////////////////////////////////////////////////////////////////////////
  // Flit layout

  // Declared MSB first, so valid lands on bit 0
  // and state occupies the top nibble
  typedef struct packed {
    logic [STATE_W-1:0]  state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic                dvalid;
    logic [CRC_W-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } flit_t;

endpackage

//--- phy_pkg.sv
// PHY lane word layout, lane status and APB register map for the die-to-die link
package phy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane word

  // 80-bit lane word, 78 payload bits
  localparam int LANE_W    = 80;
  localparam int PAYLOAD_W = 78;

  // User bits fixed by the PHY
  // Payload fills bit 0 and bits 2 to 78
  localparam int STB_BIT   = 1;
  localparam int MRK_BIT   = 79;

  // Per-lane receive status
  typedef struct packed {
    logic strobe_err;
    logic aligned;
  } lane_status_t;

  ////////////////////////////////////////////////////////////////////////////
  // APB register map

  localparam int APB_AW  = 4;
  localparam int APB_DW  = 32;
  localparam int DELAY_W = 16;

  localparam logic [APB_AW-1:0] ADDR_DELAY_X = 4'h0;
  localparam logic [APB_AW-1:0] ADDR_DELAY_Y = 4'h4;
  localparam logic [APB_AW-1:0] ADDR_DELAY_Z = 4'h8;
  localparam logic [APB_AW-1:0] ADDR_STATUS  = 4'hC;

  // STATUS field offsets, one bit per lane from here up
  localparam int STS_ERR_LSB = 8;
  localparam int STS_ALN_LSB = 16;

  // Delay values out of reset
  localparam logic [DELAY_W-1:0] RST_DELAY_X = 16'd4;
  localparam logic [DELAY_W-1:0] RST_DELAY_Y = 16'd2;
  localparam logic [DELAY_W-1:0] RST_DELAY_Z = 16'd3;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

//--- link_cfg_apb.sv
// APB register block for online delays, link status and sticky lane strobe errors
`timescale 1ns/1ps

module link_cfg_apb #(
  parameter int NUM_LANES = 2
) (
  input  logic                                     clk_wr,
  input  logic                                     rst_n,

  // APB slave
  input  phy_pkg::apb_req_t                        apb_req,
  output phy_pkg::apb_rsp_t                        apb_rsp,

  // Delays to the sequencer
  output logic [phy_pkg::DELAY_W-1:0]              delay_x,
  output logic [phy_pkg::DELAY_W-1:0]              delay_y,
  output logic [phy_pkg::DELAY_W-1:0]              delay_z,

  // Status sources
  input  logic                                     tx_online_delay,
  input  logic                                     rx_online_delay,
  input  phy_pkg::lane_status_t [NUM_LANES-1:0]    lane_status
);

  logic                          access;
  logic                          wr_en;
  logic                          sts_wr;
  logic                          addr_ok;
  logic [phy_pkg::APB_DW-1:0]    rd_data;
  logic [phy_pkg::APB_DW-1:0]    status_word;
  logic [NUM_LANES-1:0]          sticky_err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer decode

  // Access phase, no wait states
  assign access = apb_req.psel & apb_req.penable;
  assign wr_en  = access & apb_req.pwrite;
  assign sts_wr = wr_en & (apb_req.paddr == phy_pkg::ADDR_STATUS);

  // Delay registers
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      delay_x <= phy_pkg::RST_DELAY_X;
      delay_y <= phy_pkg::RST_DELAY_Y;
      delay_z <= phy_pkg::RST_DELAY_Z;
    end else if (wr_en) begin
      // Only the low half of pwdata is kept
      case (apb_req.paddr)
        phy_pkg::ADDR_DELAY_X: delay_x <= apb_req.pwdata[phy_pkg::DELAY_W-1:0];
        phy_pkg::ADDR_DELAY_Y: delay_y <= apb_req.pwdata[phy_pkg::DELAY_W-1:0];
        phy_pkg::ADDR_DELAY_Z: delay_z <= apb_req.pwdata[phy_pkg::DELAY_W-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sticky strobe errors

  // Set wins over a same-cycle write-one clear, so no event is lost
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      sticky_err_q <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (lane_status[i].strobe_err) begin
          sticky_err_q[i] <= 1'b1;
        end else if (sts_wr && apb_req.pwdata[phy_pkg::STS_ERR_LSB+i]) begin
          sticky_err_q[i] <= 1'b0;
        end
      end
    end
  end

  // STATUS word
  always_comb begin
    status_word    = '0;
    status_word[0] = tx_online_delay;
    status_word[1] = rx_online_delay;
    for (int i = 0; i < NUM_LANES; i++) begin
      status_word[phy_pkg::STS_ERR_LSB+i] = sticky_err_q[i];
      status_word[phy_pkg::STS_ALN_LSB+i] = lane_status[i].aligned;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and response

  // Unmapped addresses read as zero
  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (apb_req.paddr)
      phy_pkg::ADDR_DELAY_X: rd_data[phy_pkg::DELAY_W-1:0] = delay_x;
      phy_pkg::ADDR_DELAY_Y: rd_data[phy_pkg::DELAY_W-1:0] = delay_y;
      phy_pkg::ADDR_DELAY_Z: rd_data[phy_pkg::DELAY_W-1:0] = delay_z;
      phy_pkg::ADDR_STATUS:  rd_data = status_word;
      default:               addr_ok = 1'b0;
    endcase
  end

  always_comb begin
    apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite) ? rd_data : '0;
    apb_rsp.pready  = 1'b1;
    // Error only in the access phase
    apb_rsp.pslverr = access & ~addr_ok;
  end

endmodule

//--- online_sequencer.sv
// Online sequencer delaying tx and rx online and raising the strobe and marker enables
`timescale 1ns/1ps

module online_sequencer (
  input  logic                        clk_wr,
  input  logic                        rst_n,

  // Raw online requests
  input  logic                        tx_online,
  input  logic                        rx_online,

  // Programmed delays in cycles
  input  logic [phy_pkg::DELAY_W-1:0] delay_x,
  input  logic [phy_pkg::DELAY_W-1:0] delay_y,
  input  logic [phy_pkg::DELAY_W-1:0] delay_z,

  output logic                        tx_online_delay,
  output logic                        rx_online_delay,
  output logic                        auto_stb_en,
  output logic                        auto_mrk_en
);

  // Sequence phases
  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_WAIT = 2'd1;
  localparam logic [1:0] PH_HOLD = 2'd2;
  localparam logic [1:0] PH_DONE = 2'd3;

  logic [1:0]                  tx_ph_q;
  logic [1:0]                  rx_ph_q;
  logic [phy_pkg::DELAY_W-1:0] tx_cnt_q;
  logic [phy_pkg::DELAY_W-1:0] rx_cnt_q;
  logic [phy_pkg::DELAY_W-1:0] lat_z_q;
  logic                        ins_en_q;

  ////////////////////////////////////////////////////////////////////////////
  // Tx sequence: delay_y to insertion, then delay_z to online

  // Down counter, a zero delay still takes one cycle
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online) begin
      tx_ph_q         <= PH_IDLE;
      tx_cnt_q        <= '0;
      lat_z_q         <= '0;
      ins_en_q        <= 1'b0;
      tx_online_delay <= 1'b0;
    end else begin
      case (tx_ph_q)
        PH_IDLE: begin
          // First online cycle, latch both delays
          tx_cnt_q <= delay_y;
          lat_z_q  <= delay_z;
          tx_ph_q  <= PH_WAIT;
        end
        PH_WAIT: begin
          if (tx_cnt_q <= 1) begin
            ins_en_q <= 1'b1;
            tx_cnt_q <= lat_z_q;
            tx_ph_q  <= PH_HOLD;
          end else begin
            tx_cnt_q <= tx_cnt_q - 1'b1;
          end
        end
        PH_HOLD: begin
          if (tx_cnt_q <= 1) begin
            tx_online_delay <= 1'b1;
            tx_ph_q         <= PH_DONE;
          end else begin
            tx_cnt_q <= tx_cnt_q - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Persistent strobe and marker share one enable
  assign auto_stb_en = ins_en_q;
  assign auto_mrk_en = ins_en_q;

  ////////////////////////////////////////////////////////////////////////////
  // Rx sequence: delay_x to online

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online) begin
      rx_ph_q         <= PH_IDLE;
      rx_cnt_q        <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      case (rx_ph_q)
        PH_IDLE: begin
          rx_cnt_q <= delay_x;
          rx_ph_q  <= PH_WAIT;
        end
        PH_WAIT: begin
          if (rx_cnt_q <= 1) begin
            rx_online_delay <= 1'b1;
            rx_ph_q         <= PH_DONE;
          end else begin
            rx_cnt_q <= rx_cnt_q - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- flit_striper.sv
// Flit striper splitting one upstream flit into per-lane payload slices
`timescale 1ns/1ps

module flit_striper #(
  parameter int NUM_LANES = 2
) (
  input  lpif_pkg::flit_t                                   ustrm,
  output logic [NUM_LANES-1:0][phy_pkg::PAYLOAD_W-1:0]      lane_payload
);

  // Total payload bits across all lanes
  localparam int TOT_W = NUM_LANES * phy_pkg::PAYLOAD_W;
  localparam int PAD_W = TOT_W - lpif_pkg::FLIT_W;

  logic [TOT_W-1:0] flat;

  ////////////////////////////////////////////////////////////////////////////
  // Flit to lane bit order

  // LSB first, flit bit 0 (valid) lands on lane 0 payload bit 0
  // Top of the last lane is zero padding
  assign flat = {{PAD_W{1'b0}}, ustrm};

  // Consecutive PAYLOAD_W slices, lane 0 lowest
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    assign lane_payload[l] = flat[l*phy_pkg::PAYLOAD_W +: phy_pkg::PAYLOAD_W];
  end

endmodule

//--- lane_slice.sv
// One PHY lane that frames the tx word and captures and checks the rx word
`timescale 1ns/1ps

module lane_slice (
  input  logic                          clk_wr,
  input  logic                          rst_n,

  // Tx side
  input  logic [phy_pkg::PAYLOAD_W-1:0] tx_payload,
  input  logic                          tx_online_delay,
  input  logic                          auto_stb_en,
  input  logic                          auto_mrk_en,
  output logic [phy_pkg::LANE_W-1:0]    tx_phy,

  // Rx side
  input  logic [phy_pkg::LANE_W-1:0]    rx_phy,
  output logic [phy_pkg::PAYLOAD_W-1:0] rx_payload,
  output phy_pkg::lane_status_t         status
);

  logic [phy_pkg::PAYLOAD_W-1:0] tx_gated;
  logic [phy_pkg::LANE_W-1:0]    tx_word;
  logic [phy_pkg::PAYLOAD_W-1:0] rx_payload_q;
  logic                          rx_stb_q;
  logic                          rx_mrk_q;
  logic                          stb_armed_q;

  ////////////////////////////////////////////////////////////////////////////
  // Tx framing

  // Payload zero until online
  assign tx_gated = tx_online_delay ? tx_payload : '0;

  // Bit 0 then bits 2..78 carry payload
  always_comb begin
    tx_word                                         = '0;
    tx_word[0]                                      = tx_gated[0];
    tx_word[phy_pkg::MRK_BIT-1:phy_pkg::STB_BIT+1]  = tx_gated[phy_pkg::PAYLOAD_W-1:1];
    tx_word[phy_pkg::STB_BIT]                       = auto_stb_en;
    tx_word[phy_pkg::MRK_BIT]                       = auto_mrk_en;
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Rx capture and check

  // Payload capture
  always_ff @(posedge clk_wr) begin
    rx_payload_q <= {rx_phy[phy_pkg::MRK_BIT-1:phy_pkg::STB_BIT+1], rx_phy[0]};
  end

  // User bits and check arming
  // Check starts once a strobe arrives, so link latency after enable is not an error
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_stb_q    <= 1'b0;
      rx_mrk_q    <= 1'b0;
      stb_armed_q <= 1'b0;
    end else begin
      rx_stb_q    <= rx_phy[phy_pkg::STB_BIT];
      rx_mrk_q    <= rx_phy[phy_pkg::MRK_BIT];
      stb_armed_q <= auto_stb_en & (stb_armed_q | rx_stb_q);
    end
  end

  assign rx_payload        = rx_payload_q;
  // Missing strobe while insertion is on
  assign status.strobe_err = auto_stb_en & stb_armed_q & ~rx_stb_q;
  assign status.aligned    = rx_stb_q & rx_mrk_q;

endmodule

//--- flit_assembler.sv
// Flit assembler merging rx lane payloads into a registered downstream flit
`timescale 1ns/1ps

module flit_assembler #(
  parameter int NUM_LANES = 2
) (
  input  logic                                          clk_wr,
  input  logic                                          rst_n,
  input  logic [NUM_LANES-1:0][phy_pkg::PAYLOAD_W-1:0]  lane_payload,
  input  logic                                          rx_online_delay,
  output lpif_pkg::flit_t                               dstrm
);

  localparam int TOT_W = NUM_LANES * phy_pkg::PAYLOAD_W;

  logic [TOT_W-1:0] flat;
  lpif_pkg::flit_t  nxt_flit;
  lpif_pkg::flit_t  flit_q;
  logic             valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Lane merge

  // Lane 0 lowest, mirrors the striper order
  assign flat     = lane_payload;
  // Padding above the flit width dropped
  assign nxt_flit = lpif_pkg::flit_t'(flat[lpif_pkg::FLIT_W-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  // Flit fields
  always_ff @(posedge clk_wr) begin
    flit_q <= nxt_flit;
  end

  // Valid held low until rx online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rx_online_delay & nxt_flit.valid;
    end
  end

  always_comb begin
    dstrm       = flit_q;
    dstrm.valid = valid_q;
  end

endmodule

//--- lpif_slave_top.sv
// LPIF slave top joining the APB registers, sequencer, striper, lanes and assembler
`timescale 1ns/1ps

module lpif_slave_top #(
  parameter int NUM_LANES = 2
) (
  input  logic                                       clk_wr,
  input  logic                                       rst_n,

  // Online control
  input  logic                                       tx_online,
  input  logic                                       rx_online,

  // Link layer flits
  input  lpif_pkg::flit_t                            ustrm,
  output lpif_pkg::flit_t                            dstrm,

  // PHY lanes
  output logic [NUM_LANES-1:0][phy_pkg::LANE_W-1:0]  tx_phy,
  input  logic [NUM_LANES-1:0][phy_pkg::LANE_W-1:0]  rx_phy,

  // Configuration bus
  input  phy_pkg::apb_req_t                          apb_req,
  output phy_pkg::apb_rsp_t                          apb_rsp
);

  logic [phy_pkg::DELAY_W-1:0]                  delay_x;
  logic [phy_pkg::DELAY_W-1:0]                  delay_y;
  logic [phy_pkg::DELAY_W-1:0]                  delay_z;
  logic                                         tx_online_delay;
  logic                                         rx_online_delay;
  logic                                         auto_stb_en;
  logic                                         auto_mrk_en;
  logic [NUM_LANES-1:0][phy_pkg::PAYLOAD_W-1:0] tx_payload;
  logic [NUM_LANES-1:0][phy_pkg::PAYLOAD_W-1:0] rx_payload;
  phy_pkg::lane_status_t [NUM_LANES-1:0]        lane_status;

  ////////////////////////////////////////////////////////////////////////////
  // Control

  link_cfg_apb #(.NUM_LANES(NUM_LANES)) i_link_cfg_apb (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .delay_x         (delay_x),
    .delay_y         (delay_y),
    .delay_z         (delay_z),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .lane_status     (lane_status)
  );

  online_sequencer i_online_sequencer (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x         (delay_x),
    .delay_y         (delay_y),
    .delay_z         (delay_z),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .auto_stb_en     (auto_stb_en),
    .auto_mrk_en     (auto_mrk_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath

  flit_striper #(.NUM_LANES(NUM_LANES)) i_flit_striper (
    .ustrm        (ustrm),
    .lane_payload (tx_payload)
  );

  // One lane per PHY word
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    lane_slice i_lane_slice (
      .clk_wr          (clk_wr),
      .rst_n           (rst_n),
      .tx_payload      (tx_payload[l]),
      .tx_online_delay (tx_online_delay),
      .auto_stb_en     (auto_stb_en),
      .auto_mrk_en     (auto_mrk_en),
      .tx_phy          (tx_phy[l]),
      .rx_phy          (rx_phy[l]),
      .rx_payload      (rx_payload[l]),
      .status          (lane_status[l])
    );
  end

  flit_assembler #(.NUM_LANES(NUM_LANES)) i_flit_assembler (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .lane_payload    (rx_payload),
    .rx_online_delay (rx_online_delay),
    .dstrm           (dstrm)
  );

endmodule

//--- lpif_slave_sva.sv
// Bound assertions on the APB handshake and the online ordering of the LPIF slave
`timescale 1ns/1ps

module lpif_slave_sva (
  input logic              clk_wr,
  input logic              rst_n,
  input phy_pkg::apb_req_t apb_req,
  input phy_pkg::apb_rsp_t apb_rsp,
  input logic              tx_online,
  input logic              tx_online_delay,
  input logic              auto_stb_en
);

  // No wait states
  a_pready : assert property (@(posedge clk_wr) disable iff (!rst_n) apb_rsp.pready)
    else $error("pready low");

  // Access phase needs a setup phase before it
  a_setup : assert property (@(posedge clk_wr) disable iff (!rst_n)
    apb_req.penable |-> $past(apb_req.psel && !apb_req.penable))
    else $error("penable without setup cycle");

  // Insertion is on before the link goes online
  a_stb_on : assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_online_delay |-> auto_stb_en)
    else $error("tx online without strobe insertion");

  // Dropping tx_online clears the delayed state next cycle
  a_tx_drop : assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online |=> !tx_online_delay)
    else $error("tx_online_delay high after tx_online dropped");

endmodule

bind lpif_slave_top lpif_slave_sva i_lpif_slave_sva (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .apb_req         (apb_req),
  .apb_rsp         (apb_rsp),
  .tx_online       (tx_online),
  .tx_online_delay (tx_online_delay),
  .auto_stb_en     (auto_stb_en)
);

//--- tb_lpif_slave.sv
// Testbench for the LPIF slave with PHY loopback, random flits and a reference model
`timescale 1ns/1ps

module tb_lpif_slave;

  localparam int NUM_LANES = 2;
  localparam int NUM_TESTS = 5;
  localparam int N_FLITS   = 300;
  localparam int HIST_N    = 4096;

  logic                                      clk_wr;
  logic                                      rst_n;
  logic                                      tx_online;
  logic                                      rx_online;
  lpif_pkg::flit_t                           ustrm = '0;
  lpif_pkg::flit_t                           dstrm;
  logic [NUM_LANES-1:0][phy_pkg::LANE_W-1:0] tx_phy;
  logic [NUM_LANES-1:0][phy_pkg::LANE_W-1:0] rx_phy;
  phy_pkg::apb_req_t                         apb_req;
  phy_pkg::apb_rsp_t                         apb_rsp;

  // Loopback corruption of lane 1 strobe
  logic   corrupt;
  integer seed = 84;

  // Reference model state
  int   cyc;
  int   n_flits;
  int   tx_cnt;
  int   rx_cnt;
  int   dx = 4;
  int   dy = 2;
  int   dz = 3;
  lpif_pkg::flit_t hist [HIST_N];
  logic txon_h [HIST_N];
  logic rxon_h [HIST_N];
  logic ins_h [HIST_N];

  lpif_slave_top #(.NUM_LANES(NUM_LANES)) i_lpif_slave_top (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .ustrm     (ustrm),
    .dstrm     (dstrm),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // PHY loopback
  always_comb begin
    rx_phy = tx_phy;
    if (corrupt) begin
      rx_phy[1][phy_pkg::STB_BIT] = 1'b0;
    end
  end

  // Random flit every cycle
  always @(negedge clk_wr) begin
    logic [159:0] r;
    r     = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    ustrm = r[lpif_pkg::FLIT_W-1:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flit(input string name, input lpif_pkg::flit_t got,
                            input lpif_pkg::flit_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s got %h exp %h", $time, name, got, exp));
    end
  endtask

  task automatic check_apb(input string name, input phy_pkg::apb_rsp_t got,
                           input phy_pkg::apb_rsp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s got %h exp %h", $time, name, got, exp));
    end
  endtask

  task automatic check_lane(input string name, input logic [phy_pkg::LANE_W-1:0] got,
                            input logic [phy_pkg::LANE_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s got %h exp %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t %s got %b exp %b", $time, name, got, exp));
    end
  endtask

  function automatic phy_pkg::apb_rsp_t apb_resp(input logic [31:0] data, input logic err);
    phy_pkg::apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;
    r.pslverr = err;
    return r;
  endfunction

  // Expected dstrm for a flit that entered 3 cycles earlier
  // Payload zero unless tx was online
  // Valid needs rx online too
  function automatic lpif_pkg::flit_t exp_flit(input lpif_pkg::flit_t src,
                                               input logic src_txon, input logic rxon);
    lpif_pkg::flit_t f;
    f       = src_txon ? src : '0;
    f.valid = f.valid & rxon;
    return f;
  endfunction

  // Expected PHY word of one lane for a flit entering in the cycle before
  // Flit bits LSB first over the lanes, lane payload at bit 0 then bits 2 up
  function automatic logic [phy_pkg::LANE_W-1:0] exp_lane(input lpif_pkg::flit_t src,
                                                          input logic src_txon,
                                                          input logic ins, input int lane);
    logic [phy_pkg::LANE_W-1:0] w;
    int                         fb;
    w = '0;
    for (int p = 0; p < phy_pkg::PAYLOAD_W; p++) begin
      fb = lane * phy_pkg::PAYLOAD_W + p;
      if (src_txon && fb < lpif_pkg::FLIT_W) begin
        w[(p == 0) ? 0 : p + 1] = src[fb];
      end
    end
    w[phy_pkg::STB_BIT] = ins;
    w[phy_pkg::MRK_BIT] = ins;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // APB transfers with a setup cycle then an access cycle

  task automatic apb_write(input logic [phy_pkg::APB_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk_wr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk_wr);
    apb_req.penable = 1'b1;
    @(negedge clk_wr);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_read(input logic [phy_pkg::APB_AW-1:0] addr,
                          output phy_pkg::apb_rsp_t rsp);
    @(negedge clk_wr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk_wr);
    apb_req.penable = 1'b1;
    // Response is settled by the access edge
    @(posedge clk_wr);
    rsp = apb_rsp;
    @(negedge clk_wr);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare

  // Online predictions from consecutive online cycles
  always @(posedge clk_wr) begin
    logic                       txon_p;
    logic                       rxon_p;
    int                         n;
    if (!rst_n) begin
      cyc    = 0;
      tx_cnt = 0;
      rx_cnt = 0;
    end else begin
      n         = cyc;
      txon_p    = (tx_cnt >= dy + dz + 1);
      rxon_p    = (rx_cnt >= dx + 1);
      hist[n]   = ustrm;
      txon_h[n] = txon_p;
      rxon_h[n] = rxon_p;
      ins_h[n]  = (tx_cnt >= dy + 1);
      check_bit("tx_online_delay", i_lpif_slave_top.tx_online_delay, txon_p);
      check_bit("rx_online_delay", i_lpif_slave_top.rx_online_delay, rxon_p);
      // Lane framing one cycle after the striper
      if (n >= 1) begin
        for (int l = 0; l < NUM_LANES; l++) begin
          check_lane($sformatf("tx_phy[%0d]", l), tx_phy[l],
                     exp_lane(hist[n-1], txon_h[n-1], ins_h[n-1], l));
        end
      end
      if (n >= 3) begin
        check_flit("dstrm", dstrm, exp_flit(hist[n-3], txon_h[n-3], rxon_h[n-1]));
        if (txon_h[n-3] && rxon_h[n-1]) begin
          n_flits++;
        end
      end
      tx_cnt = tx_online ? tx_cnt + 1 : 0;
      rx_cnt = rx_online ? rx_cnt + 1 : 0;
      cyc    = n + 1;
    end
  end

  initial begin
    repeat (NUM_TESTS * 200 + 1000) @(posedge clk_wr);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    phy_pkg::apb_rsp_t rsp;
    int                start;
    int                polls;
    int                flit_base;
    rst_n     = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    corrupt   = 1'b0;
    apb_req   = '0;
    repeat (2) @(negedge clk_wr);
    rst_n = 1'b1;

    // APB reset values, readback and an unmapped address
    apb_read(phy_pkg::ADDR_DELAY_X, rsp);
    check_apb("delay_x reset", rsp, apb_resp(32'd4, 1'b0));
    apb_read(phy_pkg::ADDR_DELAY_Y, rsp);
    check_apb("delay_y reset", rsp, apb_resp(32'd2, 1'b0));
    apb_read(phy_pkg::ADDR_DELAY_Z, rsp);
    check_apb("delay_z reset", rsp, apb_resp(32'd3, 1'b0));
    apb_write(phy_pkg::ADDR_DELAY_X, 32'h0000_1234);
    apb_write(phy_pkg::ADDR_DELAY_Y, 32'h0000_00a5);
    apb_write(phy_pkg::ADDR_DELAY_Z, 32'h0000_beef);
    apb_read(phy_pkg::ADDR_DELAY_X, rsp);
    check_apb("delay_x readback", rsp, apb_resp(32'h0000_1234, 1'b0));
    apb_read(phy_pkg::ADDR_DELAY_Y, rsp);
    check_apb("delay_y readback", rsp, apb_resp(32'h0000_00a5, 1'b0));
    apb_read(phy_pkg::ADDR_DELAY_Z, rsp);
    check_apb("delay_z readback", rsp, apb_resp(32'h0000_beef, 1'b0));
    // Address 0x2 is outside the map
    apb_read(4'h2, rsp);
    check_apb("unmapped read", rsp, apb_resp(32'h0, 1'b1));

    // Online sequencing
    apb_write(phy_pkg::ADDR_DELAY_X, 32'd5);
    apb_write(phy_pkg::ADDR_DELAY_Y, 32'd3);
    apb_write(phy_pkg::ADDR_DELAY_Z, 32'd4);
    dx = 5;
    dy = 3;
    dz = 4;
    @(negedge clk_wr);
    tx_online = 1'b1;
    rx_online = 1'b1;
    start     = cyc;
    polls     = 0;
    rsp       = '0;
    while (!(rsp.prdata[0] && rsp.prdata[1])) begin
      apb_read(phy_pkg::ADDR_STATUS, rsp);
      if (rsp.prdata[0]) begin
        check_bit("STATUS tx online too early", (cyc - start) >= 7, 1'b1);
      end
      if (rsp.prdata[1]) begin
        check_bit("STATUS rx online too early", (cyc - start) >= 5, 1'b1);
      end
      polls++;
      if (polls > 20) begin
        abort_run("STATUS online bits never rose");
      end
    end
    @(negedge clk_wr);
    tx_online = 1'b0;
    rx_online = 1'b0;
    repeat (2) @(negedge clk_wr);
    apb_read(phy_pkg::ADDR_STATUS, rsp);
    check_bit("STATUS[0] after drop", rsp.prdata[0], 1'b0);
    check_bit("STATUS[1] after drop", rsp.prdata[1], 1'b0);

    // Flit transport with gating checked by the compare process
    @(negedge clk_wr);
    tx_online = 1'b1;
    rx_online = 1'b1;
    flit_base = n_flits;
    wait (n_flits >= flit_base + N_FLITS);

    // Strobe error on lane 1 for one cycle
    @(negedge clk_wr);
    corrupt = 1'b1;
    @(negedge clk_wr);
    corrupt = 1'b0;
    repeat (2) @(negedge clk_wr);
    apb_read(phy_pkg::ADDR_STATUS, rsp);
    check_bit("STATUS[9] lane 1 error", rsp.prdata[9], 1'b1);
    check_bit("STATUS[8] lane 0 error", rsp.prdata[8], 1'b0);
    apb_write(phy_pkg::ADDR_STATUS, 32'h0000_0200);
    apb_read(phy_pkg::ADDR_STATUS, rsp);
    check_bit("STATUS[9] after clear", rsp.prdata[9], 1'b0);
    check_bit("STATUS[16] lane 0 aligned", rsp.prdata[16], 1'b1);
    check_bit("STATUS[17] lane 1 aligned", rsp.prdata[17], 1'b1);

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- compile.f
lpif_pkg.sv
phy_pkg.sv
link_cfg_apb.sv
online_sequencer.sv
flit_striper.sv
lane_slice.sv
flit_assembler.sv
lpif_slave_top.sv
lpif_slave_sva.sv
tb_lpif_slave.sv

//--- Makefile
TOP := tb_lpif_slave

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
